// File: logic/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// scl pacing, four quarters make one bit
`define I2C_QUARTER_CYCLES 2
`define I2C_QCNT_W         4

// device type field of the control byte
`define EEPROM_DEVICE_CODE 4'b1010

// 2 kB part
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

`endif

// File: logic/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    typedef enum logic [1:0] {
        OP_START,       // also the repeated start
        OP_WRITE_BYTE,
        OP_READ_BYTE,
        OP_STOP
    } i2c_op_e;

    typedef enum logic [2:0] {
        BIT_IDLE,
        BIT_START,
        BIT_SHIFT_OUT,
        BIT_ACK_IN,     // slave answers our byte
        BIT_SHIFT_IN,
        BIT_ACK_OUT,    // we answer the slave
        BIT_STOP
    } bit_state_e;

endpackage

`default_nettype wire

// File: logic/eeprom_pkg.sv
`default_nettype none
`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] eeprom_addr_t;   // bits 10..8 go in the control byte
    typedef logic [`EEPROM_DATA_W-1:0] eeprom_data_t;

    typedef enum logic [3:0] {
        CMD_IDLE,
        CMD_START,
        CMD_CTRL_W,
        CMD_ADDR,
        CMD_DATA,
        CMD_RESTART,    // random read only
        CMD_CTRL_R,
        CMD_READ,
        CMD_STOP,
        CMD_DONE
    } cmd_state_e;

endpackage

`default_nettype wire

// File: logic/i2c_op_if.sv
`default_nettype none

interface i2c_op_if import i2c_pkg::*; ();
    logic       op_strobe;
    i2c_op_e    op;
    logic [7:0] tx_byte;
    logic       last_read;  // answer with nack
    logic       op_done;
    logic [7:0] rx_byte;
    logic       nack;       // valid with op_done of a byte write

    modport issuer (
        output op_strobe, op, tx_byte, last_read,
        input  op_done, rx_byte, nack
    );

    modport executor (
        input  op_strobe, op, tx_byte, last_read,
        output op_done, rx_byte, nack
    );
endinterface

`default_nettype wire

// File: logic/i2c_line_if.sv
`default_nettype none

interface i2c_line_if ();
    logic scl_level;
    logic sda_low;      // 1 pulls the data line down
    logic sda_sampled;  // after the two-flop synchronizer
    logic scl_out_now;  // what the pin carries right now

    modport engine (
        output scl_level, sda_low,
        input  sda_sampled, scl_out_now
    );

    modport pins (
        input  scl_level, sda_low,
        output sda_sampled, scl_out_now
    );
endinterface

`default_nettype wire

// File: logic/eeprom_cmd_sequencer.sv
`default_nettype none
`include "eeprom_consts.svh"

module eeprom_cmd_sequencer import i2c_pkg::*, eeprom_pkg::*; (
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire logic         wr,
    input  wire logic         rd,
    input  wire eeprom_addr_t addr,
    input  wire eeprom_data_t wdata,
    output eeprom_data_t      rdata,
    output logic              ack,
    output logic              nack_error,
    output logic              busy,
    i2c_op_if.issuer          op
);

    cmd_state_e   state;
    cmd_state_e   next_state;
    eeprom_addr_t addr_q;
    eeprom_data_t data_q;
    logic         is_read;
    logic         nack_q;       // some written byte went unanswered
    logic         op_pending;

    always_comb
    begin
        case (state)
            CMD_START:   next_state = CMD_CTRL_W;
            CMD_CTRL_W:  next_state = op.nack ? CMD_STOP : CMD_ADDR;
            CMD_ADDR:    next_state = op.nack ? CMD_STOP : (is_read ? CMD_RESTART : CMD_DATA);
            CMD_DATA:    next_state = CMD_STOP;
            CMD_RESTART: next_state = CMD_CTRL_R;
            CMD_CTRL_R:  next_state = op.nack ? CMD_STOP : CMD_READ;
            CMD_READ:    next_state = CMD_STOP;
            default:     next_state = CMD_DONE;
        endcase
    end

    // op and byte follow the state, so they hold from strobe to done
    always_comb
    begin
        case (state)
            CMD_START, CMD_RESTART:                     op.op = OP_START;
            CMD_CTRL_W, CMD_ADDR, CMD_DATA, CMD_CTRL_R: op.op = OP_WRITE_BYTE;
            CMD_READ:                                   op.op = OP_READ_BYTE;
            default:                                    op.op = OP_STOP;
        endcase
        case (state)
            CMD_CTRL_W: op.tx_byte = {`EEPROM_DEVICE_CODE, addr_q[`EEPROM_ADDR_W-1:8], 1'b0};
            CMD_ADDR:   op.tx_byte = addr_q[7:0];
            CMD_DATA:   op.tx_byte = data_q;
            CMD_CTRL_R: op.tx_byte = {`EEPROM_DEVICE_CODE, addr_q[`EEPROM_ADDR_W-1:8], 1'b1};
            default:    op.tx_byte = 8'h00;
        endcase
    end

    assign op.last_read = (state == CMD_READ);  // single byte read ends with nack

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= CMD_IDLE;
            is_read      <= 1'b0;
            nack_q       <= 1'b0;
            busy         <= 1'b0;
            ack          <= 1'b0;
            nack_error   <= 1'b0;
            rdata        <= '0;
            op.op_strobe <= 1'b0;
        end
        else
        begin
            op.op_strobe <= 1'b0;
            ack          <= 1'b0;
            case (state)
                CMD_IDLE, CMD_DONE:     // busy is already low in done
                    if (wr || rd)
                    begin
                        addr_q       <= addr;
                        data_q       <= wdata;
                        is_read      <= !wr;    // wr wins a tie
                        nack_q       <= 1'b0;
                        nack_error   <= 1'b0;
                        busy         <= 1'b1;
                        state        <= CMD_START;
                        op.op_strobe <= 1'b1;
                    end
                    else
                        state <= CMD_IDLE;
                default:
                    if (op.op_done)
                    begin
                        state <= next_state;
                        if (op.op == OP_WRITE_BYTE && op.nack)
                            nack_q <= 1'b1;
                        if (state == CMD_READ)
                            rdata <= op.rx_byte;
                        if (state == CMD_STOP)
                        begin
                            ack        <= 1'b1;
                            busy       <= 1'b0;
                            nack_error <= nack_q;
                        end
                        else
                            op.op_strobe <= 1'b1;
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            op_pending <= 1'b0;
        else if (op.op_strobe)
            op_pending <= 1'b1;
        else if (op.op_done)
            op_pending <= 1'b0;
    end

    // one operation in flight toward the bit engine
    a_one_op_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        op.op_strobe |-> !op_pending);

endmodule

`default_nettype wire

// File: logic/i2c_bit_engine.sv
`default_nettype none
`include "eeprom_consts.svh"

module i2c_bit_engine import i2c_pkg::*; (
    input  wire logic  CLK,
    input  wire logic  RESET,
    i2c_op_if.executor op,
    i2c_line_if.engine line
);

    localparam logic [`I2C_QCNT_W-1:0] QUARTER_LAST = `I2C_QUARTER_CYCLES - 1;

    bit_state_e             state;
    logic [`I2C_QCNT_W-1:0] qcnt;
    logic [1:0]             qidx;       // quarter within bit, start or stop
    logic [2:0]             bitcnt;
    logic [7:0]             shreg;
    logic                   q_end;
    logic                   bit_drive;

    // the high quarter waits until the pin really is high
    assign q_end = (qcnt == QUARTER_LAST) && (qidx != 2'd2 || line.scl_out_now);

    always_comb
    begin
        case (state)
            BIT_SHIFT_OUT: bit_drive = !shreg[7];       // msb first
            BIT_ACK_OUT:   bit_drive = !op.last_read;
            default:       bit_drive = 1'b0;            // released for the slave
        endcase
    end

    assign op.rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state          <= BIT_IDLE;
            qcnt           <= '0;
            qidx           <= '0;
            bitcnt         <= '0;
            line.scl_level <= 1'b1;
            line.sda_low   <= 1'b0;
            op.op_done     <= 1'b0;
            op.nack        <= 1'b0;
        end
        else
        begin
            op.op_done <= 1'b0;
            if (state == BIT_IDLE || q_end)
                qcnt <= '0;
            else if (qcnt != QUARTER_LAST)
                qcnt <= qcnt + 1'b1;
            case (state)
                BIT_IDLE:
                    if (op.op_strobe)
                    begin
                        qidx   <= 2'd0;
                        bitcnt <= 3'd0;
                        shreg  <= op.tx_byte;
                        case (op.op)
                            OP_START:
                            begin
                                state          <= BIT_START;
                                line.scl_level <= 1'b1;
                                line.sda_low   <= 1'b0;
                            end
                            OP_STOP:
                            begin
                                state          <= BIT_STOP;
                                line.scl_level <= 1'b0;
                                line.sda_low   <= 1'b1;
                            end
                            OP_WRITE_BYTE:
                            begin
                                state          <= BIT_SHIFT_OUT;
                                line.scl_level <= 1'b0;
                            end
                            default:
                            begin
                                state          <= BIT_SHIFT_IN;
                                line.scl_level <= 1'b0;
                            end
                        endcase
                    end
                BIT_START:
                    if (q_end)
                    begin
                        qidx <= 2'd1;
                        if (qidx == 2'd0)
                            line.sda_low <= 1'b1;   // sda falls under high scl
                        else
                        begin
                            op.op_done <= 1'b1;
                            state      <= BIT_IDLE;
                        end
                    end
                BIT_STOP:
                    if (q_end)
                    begin
                        qidx <= 2'd1;
                        if (qidx == 2'd0)
                            line.scl_level <= 1'b1;
                        else
                        begin
                            line.sda_low <= 1'b0;   // sda rises under high scl
                            op.op_done   <= 1'b1;
                            state        <= BIT_IDLE;
                        end
                    end
                default:
                    if (q_end)
                    begin
                        qidx <= qidx + 2'd1;
                        case (qidx)
                            2'd0: line.sda_low <= bit_drive;
                            2'd1: line.scl_level <= 1'b1;
                            2'd2: line.scl_level <= 1'b0;
                            default:
                            begin
                                bitcnt <= bitcnt + 3'd1;
                                case (state)
                                    BIT_SHIFT_OUT:
                                    begin
                                        shreg <= {shreg[6:0], 1'b0};
                                        if (bitcnt == 3'd7)
                                            state <= BIT_ACK_IN;
                                    end
                                    BIT_SHIFT_IN:
                                    begin
                                        shreg <= {shreg[6:0], line.sda_sampled};
                                        if (bitcnt == 3'd7)
                                            state <= BIT_ACK_OUT;
                                    end
                                    BIT_ACK_IN:
                                    begin
                                        op.nack    <= line.sda_sampled;    // high means no ack
                                        op.op_done <= 1'b1;
                                        state      <= BIT_IDLE;
                                    end
                                    default:
                                    begin
                                        op.op_done <= 1'b1;
                                        state      <= BIT_IDLE;
                                    end
                                endcase
                            end
                        endcase
                    end
            endcase
        end
    end

    // data moves only under low scl, start and stop being the exceptions
    a_sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        $changed(line.sda_low) |-> !line.scl_level || $past(state) inside {BIT_START, BIT_STOP});

endmodule

`default_nettype wire

// File: logic/i2c_line_io.sv
`default_nettype none

module i2c_line_io (
    input  wire logic CLK,
    input  wire logic RESET,
    i2c_line_if.pins  line,
    output logic      scl,
    output logic      sda_pull_low,
    input  wire logic sda_in
);

    logic sda_meta;
    logic sda_sync;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl          <= 1'b1;   // bus released
            sda_pull_low <= 1'b0;
            sda_meta     <= 1'b1;
            sda_sync     <= 1'b1;
        end
        else
        begin
            scl          <= line.scl_level;
            sda_pull_low <= line.sda_low;
            sda_meta     <= sda_in;
            sda_sync     <= sda_meta;
        end
    end

    assign line.scl_out_now = scl;
    assign line.sda_sampled = sda_sync;

endmodule

`default_nettype wire

// File: logic/eeprom_i2c_top.sv
`default_nettype none

module eeprom_i2c_top import eeprom_pkg::*; (
    input  wire logic         CLK,
    input  wire logic         RESET,
    input  wire logic         wr,
    input  wire logic         rd,
    input  wire eeprom_addr_t addr,
    input  wire eeprom_data_t wdata,
    output wire eeprom_data_t rdata,
    output wire logic         ack,
    output wire logic         nack_error,
    output wire logic         busy,
    output wire logic         scl,
    output wire logic         sda_pull_low,
    input  wire logic         sda_in
);

    i2c_op_if   op_bus ();
    i2c_line_if line_bus ();

    eeprom_cmd_sequencer u_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .ack        (ack),
        .nack_error (nack_error),
        .busy       (busy),
        .op         (op_bus.issuer)
    );

    i2c_bit_engine u_bit_engine (
        .CLK   (CLK),
        .RESET (RESET),
        .op    (op_bus.executor),
        .line  (line_bus.engine)
    );

    i2c_line_io u_line_io (
        .CLK          (CLK),
        .RESET        (RESET),
        .line         (line_bus.pins),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

endmodule

`default_nettype wire

// File: testbench/eeprom_slave_model.sv
`default_nettype none

module eeprom_slave_model (
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic scl,
    input  wire logic sda_pull_low,   // master side of the wired line
    input  wire logic force_nack,     // withhold the address byte ack
    output logic      sda,
    output int        violations,
    output int        stops
);

    logic [7:0]  mem [0:2047];
    logic        prev_scl;
    logic        prev_sda;
    logic        drive_low;
    logic        reading;
    logic        read_next;
    logic        skip_fall;   // scl fall right after a start carries no bit
    logic [3:0]  bit_cnt;
    logic [1:0]  byte_idx;
    logic [7:0]  in_byte;
    logic [7:0]  out_byte;
    logic [2:0]  block;
    logic [7:0]  word;

    assign sda = !(sda_pull_low || drive_low);

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'h00;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            prev_scl   <= 1'b1;
            prev_sda   <= 1'b1;
            drive_low  <= 1'b0;
            reading    <= 1'b0;
            read_next  <= 1'b0;
            skip_fall  <= 1'b0;
            bit_cnt    <= 4'd0;
            byte_idx   <= 2'd0;
            violations <= 0;
            stops      <= 0;
        end
        else
        begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (prev_scl && scl && prev_sda != sda)
            begin
                // start or stop; mid-byte means the master broke the frame
                if (bit_cnt != 4'd0)
                    violations <= violations + 1;
                bit_cnt   <= 4'd0;
                byte_idx  <= 2'd0;
                reading   <= 1'b0;
                read_next <= 1'b0;
                drive_low <= 1'b0;
                skip_fall <= !sda;
                if (sda)
                    stops <= stops + 1;
            end
            else if (!prev_scl && scl)
            begin
                if (!reading)
                    in_byte <= {in_byte[6:0], sda};
            end
            else if (prev_scl && !scl)
            begin
                if (skip_fall)
                    skip_fall <= 1'b0;
                else if (bit_cnt < 4'd7)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (reading)
                    begin
                        drive_low <= !out_byte[6];
                        out_byte  <= {out_byte[6:0], 1'b0};
                    end
                end
                else if (bit_cnt == 4'd7)
                begin
                    bit_cnt   <= 4'd8;
                    drive_low <= 1'b0;  // released for the master ack when reading
                    if (!reading)
                    begin
                        case (byte_idx)
                            2'd0:
                                if (in_byte[7:4] == 4'b1010)
                                begin
                                    block     <= in_byte[3:1];
                                    read_next <= in_byte[0];
                                    byte_idx  <= 2'd1;
                                    drive_low <= 1'b1;
                                end
                            2'd1:
                            begin
                                word      <= in_byte;
                                byte_idx  <= 2'd2;
                                drive_low <= !force_nack;
                            end
                            2'd2:
                            begin
                                mem[{block, word}] <= in_byte;
                                byte_idx           <= 2'd3;
                                drive_low          <= 1'b1;
                            end
                            default: drive_low <= 1'b0;
                        endcase
                    end
                end
                else
                begin
                    bit_cnt   <= 4'd0;
                    reading   <= read_next;
                    read_next <= 1'b0;
                    drive_low <= read_next ? !mem[{block, word}][7] : 1'b0;
                    out_byte  <= mem[{block, word}];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_eeprom_i2c.sv
`default_nettype none
`include "eeprom_consts.svh"

module tb_eeprom_i2c import i2c_pkg::*, eeprom_pkg::*; ();

    logic         CLK;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    eeprom_data_t wdata;
    eeprom_data_t rdata;
    logic         ack;
    logic         nack_error;
    logic         busy;
    logic         scl;
    logic         sda_pull_low;
    logic         sda;
    logic         force_nack;
    int           violations;
    int           stop_count;

    int           op_list[$];     // 0 write, 1 read, 2 write with a strobe while busy
    eeprom_addr_t addr_list[$];
    eeprom_data_t data_list[$];
    logic         nack_list[$];
    eeprom_data_t exp_list[$];

    int data_errors;
    int flag_errors;
    int count_errors;
    int cycles;
    int cycle_limit;

    eeprom_i2c_top DUT (
        .CLK          (CLK),
        .RESET        (RESET),
        .wr           (wr),
        .rd           (rd),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .ack          (ack),
        .nack_error   (nack_error),
        .busy         (busy),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda)
    );

    eeprom_slave_model slave (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .force_nack   (force_nack),
        .sda          (sda),
        .violations   (violations),
        .stops        (stop_count)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit)
        begin
            $display("timeout: no ack after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_data(input string name, input eeprom_data_t exp, input eeprom_data_t act);
        if (exp !== act)
        begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            flag_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            count_errors++;
        end
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        int    f_op;
        int    f_addr;
        int    f_data;
        int    f_nack;
        int    f_exp;
        string line;
        fd = $fopen("testbench/eeprom_patterns.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_nack, f_exp);
                    if (n == 5)
                    begin
                        op_list.push_back(f_op);
                        addr_list.push_back(eeprom_addr_t'(f_addr));
                        data_list.push_back(eeprom_data_t'(f_data));
                        nack_list.push_back(f_nack != 0);
                        exp_list.push_back(eeprom_data_t'(f_exp));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_pattern(input int idx);
        string name;
        int    stops_before;
        int    waited;
        logic  seen_ack;
        logic  inject;
        name         = $sformatf("pattern %0d", idx);
        stops_before = stop_count;
        seen_ack     = 1'b0;
        waited       = 0;
        @(posedge CLK);
        wr         <= (op_list[idx] != 1);
        rd         <= (op_list[idx] == 1);
        addr       <= addr_list[idx];
        wdata      <= data_list[idx];
        force_nack <= nack_list[idx];
        while (!seen_ack)
        begin
            inject = (op_list[idx] == 2 && waited == 5);
            @(posedge CLK);
            wr <= inject;
            rd <= 1'b0;
            if (inject)
            begin
                addr  <= eeprom_addr_t'(addr_list[idx] + 11'd1);   // must not reach memory
                wdata <= ~data_list[idx];
            end
            @(negedge CLK);
            if (ack)
                seen_ack = 1'b1;
            else
                check_flag({name, " busy"}, 1'b1, busy);
            waited++;
        end
        check_flag({name, " busy at ack"}, 1'b0, busy);
        if (op_list[idx] == 1)
        begin
            check_flag({name, " nack_error"}, 1'b0, nack_error);
            check_data({name, " rdata"}, exp_list[idx], rdata);
        end
        else
            check_flag({name, " nack_error"}, exp_list[idx][0], nack_error);
        repeat (4) @(posedge CLK);
        force_nack <= 1'b0;
        @(negedge CLK);
        check_count({name, " transactions"}, 1, stop_count - stops_before);
    endtask

    initial
    begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = '0;
        force_nack   = 1'b0;
        data_errors  = 0;
        flag_errors  = 0;
        count_errors = 0;
        cycles       = 0;
        cycle_limit  = 0;
        load_patterns();
        if (op_list.size() == 0)
        begin
            $display("no pattern could be read from testbench/eeprom_patterns.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end
        else
        begin
            cycle_limit = op_list.size() * 50 * 4 * `I2C_QUARTER_CYCLES + 10;
            repeat (10) @(posedge CLK);
            RESET <= 1'b0;
            @(negedge CLK);
            check_flag("reset scl", 1'b1, scl);
            check_flag("reset sda_pull_low", 1'b0, sda_pull_low);
            check_flag("reset busy", 1'b0, busy);
            check_flag("reset ack", 1'b0, ack);
            check_flag("reset nack_error", 1'b0, nack_error);
            check_data("reset rdata", 8'h00, rdata);
            for (int i = 0; i < op_list.size(); i++)
                run_pattern(i);
            check_count("protocol violations", 0, violations);
            $display("errors: %0d data, %0d flag, %0d count",
                     data_errors, flag_errors, count_errors);
            if (data_errors + flag_errors + count_errors == 0)
                $display("TEST RESULT: PASS");
            else
                $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/eeprom_patterns.txt
# op addr data force_nack expected, all hex
# op 0 write, 1 read, 2 write with a second strobe while busy; expected is nack_error or rdata
0 005 a5 0 0
1 005 00 0 a5
0 105 3c 0 0
0 705 c3 0 0
1 005 00 0 a5
1 105 00 0 3c
1 705 00 0 c3
0 105 77 1 1
1 105 00 0 3c
2 2f0 5a 0 0
1 2f0 00 0 5a
1 2f1 00 0 00
0 7ff ff 0 0
1 7ff 00 0 ff
1 0ff 00 0 00

// File: eeprom_i2c.f
+incdir+logic
logic/i2c_pkg.sv
logic/eeprom_pkg.sv
logic/i2c_op_if.sv
logic/i2c_line_if.sv
logic/eeprom_cmd_sequencer.sv
logic/i2c_bit_engine.sv
logic/i2c_line_io.sv
logic/eeprom_i2c_top.sv
testbench/eeprom_slave_model.sv
testbench/tb_eeprom_i2c.sv

// File: run_sim.sh
#!/bin/sh
# build and run the eeprom controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f eeprom_i2c.f --top-module tb_eeprom_i2c

./obj_dir/Vtb_eeprom_i2c > sim.log
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
